//--- Bender.yml
package:
  name: shift_add_multiplier

dependencies: {}

sources:
  # Packages first, then the blocks and the top level
  - files:
      - hdl/mult_pkg.sv
      - hdl/mult_ctrl_pkg.sv
      - hdl/bit_sequencer.sv
      - hdl/mult_controller.sv
      - hdl/product_accumulator.sv
      - hdl/shift_add_multiplier.sv

  # Simulation only
  - target: test
    files:
      - tb/shift_add_multiplier_properties.sv
      - tb/shift_add_multiplier_tb.sv

//--- compile.f
hdl/mult_pkg.sv
hdl/mult_ctrl_pkg.sv
hdl/bit_sequencer.sv
hdl/mult_controller.sv
hdl/product_accumulator.sv
hdl/shift_add_multiplier.sv
tb/shift_add_multiplier_properties.sv
tb/shift_add_multiplier_tb.sv

//--- hdl/bit_sequencer.sv
`timescale 1ns/1ps

module bit_sequencer (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            enable_a,
    input  logic                            enable_b,
    input  logic                            count_en,
    input  logic                            clear_count,
    input  logic [mult_pkg::OP_WIDTH-1:0]   operand_a,
    input  logic [mult_pkg::OP_WIDTH-1:0]   operand_b,
    output logic                            b_val,
    output logic                            stop,
    output logic [mult_pkg::PROD_WIDTH-1:0] a_term
);

    logic [mult_pkg::PROD_WIDTH-1:0] mcand_q; // Multiplicand, moves left one bit per step
    logic [mult_pkg::OP_WIDTH-1:0]   mplier_q; // Multiplier, moves right one bit per step
    logic [mult_pkg::CNT_WIDTH-1:0]  count_q;

    always_ff @(posedge CLK)
    begin
        if (enable_a)
            mcand_q <= mult_pkg::PROD_WIDTH'(operand_a);
        else if (count_en)
            mcand_q <= mcand_q << 1;
    end

    always_ff @(posedge CLK)
    begin
        if (enable_b)
            mplier_q <= operand_b;
        else if (count_en)
            mplier_q <= mplier_q >> 1;
    end

    // Step counter
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            count_q <= '0;
        else if (clear_count)
            count_q <= '0;
        else if (count_en)
            count_q <= count_q + 1'b1;
    end

    assign b_val  = mplier_q[0];
    assign a_term = mcand_q;
    assign stop   = (count_q == mult_pkg::CNT_WIDTH'(mult_pkg::OP_WIDTH - 1)); // Last step

endmodule

//--- hdl/mult_controller.sv
`timescale 1ns/1ps

module mult_controller (
    input  logic CLK,
    input  logic RST,
    input  logic stop,
    input  logic b_val,
    input  logic src_valid_in,   // Operands offered by the source
    input  logic dist_ready_out, // Destination takes the product
    output logic enable_a,
    output logic enable_b,
    output logic a_sel,
    output logic comp_sel,
    output logic count_en,
    output logic clear_product,
    output logic clear_count,
    output logic dist_valid_out, // Product available
    output logic src_ready_in    // Free to accept operands
);

    mult_ctrl_pkg::ctrl_state_e c_state;
    mult_ctrl_pkg::ctrl_state_e n_state;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            c_state <= mult_ctrl_pkg::ST_IDLE;
        else
            c_state <= n_state;
    end

    // Next state
    always_comb
    begin
        n_state = c_state;
        case (c_state)
            mult_ctrl_pkg::ST_IDLE:
            begin
                if (src_valid_in)
                    n_state = mult_ctrl_pkg::ST_COMPUTE;
            end

            mult_ctrl_pkg::ST_COMPUTE:
            begin
                if (stop)
                    n_state = mult_ctrl_pkg::ST_DONE; // Last bit goes into the result
            end

            mult_ctrl_pkg::ST_DONE:
            begin
                if (dist_ready_out)
                    n_state = mult_ctrl_pkg::ST_IDLE;
            end

            default:
            begin
                n_state = mult_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    // Strobes and handshake outputs
    always_comb
    begin
        enable_a       = 1'b0;
        enable_b       = 1'b0;
        a_sel          = 1'b0;
        comp_sel       = 1'b0;
        count_en       = 1'b0;
        clear_product  = 1'b0;
        clear_count    = 1'b0;
        dist_valid_out = 1'b0;
        src_ready_in   = 1'b0;

        case (c_state)
            mult_ctrl_pkg::ST_IDLE:
            begin
                src_ready_in = 1'b1;
                if (src_valid_in)
                begin
                    // Capture operands and start from a clean partial product
                    enable_a      = 1'b1;
                    enable_b      = 1'b1;
                    clear_product = 1'b1;
                    clear_count   = 1'b1;
                end
            end

            mult_ctrl_pkg::ST_COMPUTE:
            begin
                a_sel = b_val; // Add shifted multiplicand only for set bits
                if (stop)
                    comp_sel = 1'b1;
                else
                    count_en = 1'b1;
            end

            mult_ctrl_pkg::ST_DONE:
            begin
                dist_valid_out = 1'b1;
            end

            default:
            begin
                src_ready_in = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/mult_ctrl_pkg.sv
package mult_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00, // Waiting for operands
        ST_COMPUTE = 2'b01, // One multiplier bit per clock
        ST_DONE    = 2'b10  // Product held for the destination
    } ctrl_state_e;

endpackage

//--- hdl/mult_pkg.sv
package mult_pkg;

    // Operand and product widths of the multiplier
    localparam int OP_WIDTH   = 8;
    localparam int PROD_WIDTH = 2 * OP_WIDTH;

    // Step counter covers OP_WIDTH steps, 0 to OP_WIDTH-1
    localparam int CNT_WIDTH  = $clog2(OP_WIDTH);

endpackage

//--- hdl/product_accumulator.sv
`timescale 1ns/1ps

module product_accumulator (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            clear_product,
    input  logic                            a_sel,
    input  logic                            comp_sel,
    input  logic [mult_pkg::PROD_WIDTH-1:0] a_term,
    output logic [mult_pkg::PROD_WIDTH-1:0] product
);

    logic [mult_pkg::PROD_WIDTH-1:0] partial_q;
    logic [mult_pkg::PROD_WIDTH-1:0] term_sel;
    logic [mult_pkg::PROD_WIDTH-1:0] sum;

    // Term is only added when the current multiplier bit is set
    assign term_sel = a_sel ? a_term : '0;
    assign sum      = partial_q + term_sel;

    always_ff @(posedge CLK)
    begin
        if (clear_product)
            partial_q <= '0;
        else if (a_sel)
            partial_q <= sum;
    end

    // Result register, written once per operation on the final step
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
            product <= '0;
        else if (comp_sel)
            product <= sum; // Includes the last bit's term
    end

endmodule

//--- hdl/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            src_valid_in,
    input  logic [mult_pkg::OP_WIDTH-1:0]   operand_a,
    input  logic [mult_pkg::OP_WIDTH-1:0]   operand_b,
    input  logic                            dist_ready_out,
    output logic                            src_ready_in,
    output logic                            dist_valid_out,
    output logic [mult_pkg::PROD_WIDTH-1:0] product
);

    logic                            enable_a;
    logic                            enable_b;
    logic                            count_en;
    logic                            clear_count;
    logic                            clear_product;
    logic                            a_sel;
    logic                            comp_sel;
    logic                            b_val;
    logic                            stop;
    logic [mult_pkg::PROD_WIDTH-1:0] a_term;

    bit_sequencer seq_i (
        .CLK         (CLK),
        .RST         (RST),
        .enable_a    (enable_a),
        .enable_b    (enable_b),
        .count_en    (count_en),
        .clear_count (clear_count),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .b_val       (b_val),
        .stop        (stop),
        .a_term      (a_term)
    );

    mult_controller ctrl_i (
        .CLK            (CLK),
        .RST            (RST),
        .stop           (stop),
        .b_val          (b_val),
        .src_valid_in   (src_valid_in),
        .dist_ready_out (dist_ready_out),
        .enable_a       (enable_a),
        .enable_b       (enable_b),
        .a_sel          (a_sel),
        .comp_sel       (comp_sel),
        .count_en       (count_en),
        .clear_product  (clear_product),
        .clear_count    (clear_count),
        .dist_valid_out (dist_valid_out),
        .src_ready_in   (src_ready_in)
    );

    product_accumulator acc_i (
        .CLK           (CLK),
        .RST           (RST),
        .clear_product (clear_product),
        .a_sel         (a_sel),
        .comp_sel      (comp_sel),
        .a_term        (a_term),
        .product       (product)
    );

endmodule

//--- tb/shift_add_multiplier_properties.sv
`timescale 1ns/1ps

module shift_add_multiplier_properties (
    input logic                            CLK,
    input logic                            RST,
    input logic                            src_ready_in,
    input logic                            dist_valid_out,
    input logic                            dist_ready_out,
    input logic [mult_pkg::PROD_WIDTH-1:0] product,
    input logic [1:0]                      state
);

    int assert_fail_count = 0;

    // Idle and done never overlap
    ready_valid_exclusive: assert property (@(posedge CLK) disable iff (!RST)
        !(src_ready_in && dist_valid_out))
        else
        begin
            $error("src_ready_in and dist_valid_out high together");
            assert_fail_count++;
        end

    valid_held: assert property (@(posedge CLK) disable iff (!RST)
        dist_valid_out && !dist_ready_out |=> dist_valid_out)
        else
        begin
            $error("dist_valid_out dropped without a transfer");
            assert_fail_count++;
        end

    product_stable: assert property (@(posedge CLK) disable iff (!RST)
        dist_valid_out && !dist_ready_out |=> $stable(product))
        else
        begin
            $error("product changed under back-pressure");
            assert_fail_count++;
        end

    state_legal: assert property (@(posedge CLK) disable iff (!RST)
        state inside {mult_ctrl_pkg::ST_IDLE, mult_ctrl_pkg::ST_COMPUTE, mult_ctrl_pkg::ST_DONE})
        else
        begin
            $error("controller state outside the enum");
            assert_fail_count++;
        end

endmodule

bind shift_add_multiplier shift_add_multiplier_properties props_i (
    .CLK            (CLK),
    .RST            (RST),
    .src_ready_in   (src_ready_in),
    .dist_valid_out (dist_valid_out),
    .dist_ready_out (dist_ready_out),
    .product        (product),
    .state          (ctrl_i.c_state)
);

//--- tb/shift_add_multiplier_tb.sv
`timescale 1ns/1ps

module shift_add_multiplier_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_TESTS   = 300;
    localparam int LATENCY     = 9;  // Edges up to dist_valid_out, accepting edge included
    localparam int MAX_STALL   = 8;
    localparam int MAX_GAP     = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (LATENCY + MAX_STALL + MAX_GAP + 2) + 100;

    logic                            CLK;
    logic                            RST;
    logic                            src_valid_in;
    logic [mult_pkg::OP_WIDTH-1:0]   operand_a;
    logic [mult_pkg::OP_WIDTH-1:0]   operand_b;
    logic                            dist_ready_out;
    logic                            src_ready_in;
    logic                            dist_valid_out;
    logic [mult_pkg::PROD_WIDTH-1:0] product;

    integer seed = 45;
    int     mismatch_count = 0;
    int     failure_count = 0;
    int     recv_count = 0;
    int     cycle = 0;
    int     accept_edge = 0;
    int     stall_left = 0;
    logic   next_ready = 1'b1;
    logic   in_fire = 1'b0;  // Input transfer at the coming edge
    logic   busy = 1'b0;
    logic   ready_due = 1'b0;
    logic   hold_prev = 1'b0;
    logic   valid_prev = 1'b0;
    logic [mult_pkg::PROD_WIDTH-1:0] held_product;
    logic [mult_pkg::PROD_WIDTH-1:0] expected_product;
    logic [mult_pkg::PROD_WIDTH-1:0] expected_q[$];

    shift_add_multiplier dut_i (
        .CLK            (CLK),
        .RST            (RST),
        .src_valid_in   (src_valid_in),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .dist_ready_out (dist_ready_out),
        .src_ready_in   (src_ready_in),
        .dist_valid_out (dist_valid_out),
        .product        (product)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK)
        cycle <= cycle + 1;

    task automatic flag_mismatch(input string name, input int expected, input int actual);
        begin
            mismatch_count++;
            $display("mismatch %s: expected %0d, actual %0d at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic note_failure(input string text);
        begin
            failure_count++;
            $display("error at %0t: %s", $time, text);
        end
    endtask

    function automatic logic [mult_pkg::OP_WIDTH-1:0] corner_value(input int idx);
        case (idx)
            0:       return 8'd0;
            1:       return 8'd1;
            default: return 8'd255;
        endcase
    endfunction

    // Offer one operand pair after a random idle gap, hold it until accepted
    task automatic send_pair(input logic [mult_pkg::OP_WIDTH-1:0] a,
                             input logic [mult_pkg::OP_WIDTH-1:0] b);
        int   gap;
        logic accepted;
        begin
            gap = {$random(seed)} % (MAX_GAP + 1);
            repeat (gap)
            begin
                @(posedge CLK);
                #DRIVE_DELAY;
            end
            src_valid_in = 1'b1;
            operand_a    = a;
            operand_b    = b;
            do
            begin
                @(posedge CLK);
                accepted = in_fire;
                #DRIVE_DELAY;
            end
            while (!accepted);
            src_valid_in = 1'b0;
            operand_a    = 8'($random(seed)); // Junk, operands are already captured
            operand_b    = 8'($random(seed));
        end
    endtask

    // Destination back-pressure, each stall is followed by at least one ready cycle
    always @(negedge CLK)
    begin
        if (stall_left != 0)
        begin
            next_ready = 1'b0;
            stall_left = stall_left - 1;
        end
        else if (next_ready && ({$random(seed)} % 4) == 0)
        begin
            stall_left = {$random(seed)} % MAX_STALL;
            next_ready = 1'b0;
        end
        else
            next_ready = 1'b1;
    end

    always @(posedge CLK)
    begin
        #DRIVE_DELAY;
        dist_ready_out = next_ready;
    end

    // Monitor, samples mid-cycle where everything has settled
    always @(negedge CLK)
    begin
        if (!RST)
        begin
            in_fire    = 1'b0;
            busy       = 1'b0;
            ready_due  = 1'b0;
            hold_prev  = 1'b0;
            valid_prev = 1'b0;
        end
        else
        begin
            in_fire = src_valid_in && src_ready_in;
            if (hold_prev)
            begin
                if (!dist_valid_out)
                    note_failure("dist_valid_out dropped while dist_ready_out was low");
                if (product !== held_product)
                    flag_mismatch("backpressure_hold", held_product, product);
            end
            if (busy && src_ready_in !== 1'b0)
                flag_mismatch("busy_ready", 0, src_ready_in);
            if (ready_due)
            begin
                if (src_ready_in !== 1'b1)
                    flag_mismatch("busy_ready", 1, src_ready_in);
                ready_due = 1'b0;
            end
            if (dist_valid_out && !valid_prev)
            begin
                if (!busy)
                    note_failure("dist_valid_out rose with no operands accepted");
                else if (cycle - accept_edge != LATENCY)
                    flag_mismatch("latency", LATENCY, cycle - accept_edge);
            end
            if (dist_valid_out && dist_ready_out)
            begin
                if (expected_q.size() == 0)
                    note_failure("product delivered with no operands accepted");
                else
                begin
                    expected_product = expected_q.pop_front();
                    if (product !== expected_product)
                        flag_mismatch("product_value", expected_product, product);
                end
                recv_count++;
                busy      = 1'b0;
                ready_due = 1'b1;
            end
            if (in_fire)
            begin
                // Reference model, plain unsigned product of the captured pair
                expected_q.push_back(mult_pkg::PROD_WIDTH'(operand_a) *
                                     mult_pkg::PROD_WIDTH'(operand_b));
                accept_edge = cycle; // Accepting edge counts as the first
                busy        = 1'b1;
            end
            hold_prev    = dist_valid_out && !dist_ready_out;
            held_product = product;
            valid_prev   = dist_valid_out;
        end
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("error: timeout, only %0d of %0d products delivered", recv_count, NUM_TESTS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        logic [mult_pkg::OP_WIDTH-1:0] a;
        logic [mult_pkg::OP_WIDTH-1:0] b;

        RST            = 1'b0;
        src_valid_in   = 1'b0;
        operand_a      = '0;
        operand_b      = '0;
        dist_ready_out = 1'b0;
        repeat (2) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b1;

        @(negedge CLK);
        if (src_ready_in !== 1'b1)
            flag_mismatch("reset_state", 1, src_ready_in);
        if (dist_valid_out !== 1'b0)
            flag_mismatch("reset_state", 0, dist_valid_out);
        if (product !== '0)
            flag_mismatch("reset_state", 0, product);
        @(posedge CLK);
        #DRIVE_DELAY;

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            if (i < 9)
            begin
                a = corner_value(i / 3); // 0, 1 and 255 on each side
                b = corner_value(i % 3);
            end
            else
            begin
                a = 8'($random(seed));
                b = 8'($random(seed));
            end
            send_pair(a, b);
        end

        wait (recv_count == NUM_TESTS);
        repeat (4) @(negedge CLK);
        if (expected_q.size() != 0)
            note_failure("accepted operands left without a delivered product");

        $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, failure_count, dut_i.props_i.assert_fail_count);
        if (mismatch_count == 0 && failure_count == 0 && dut_i.props_i.assert_fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
